// File: opx_core.f
+incdir+logic
logic/opx_pkg.sv
logic/opx_regfile.sv
logic/opx_fwd_ctrl.sv
logic/opx_operand_mux.sv
logic/opx_exec_stage.sv
logic/opx_core.sv
sim/opx_core_tb.sv

// File: Bender.yml
package:
  name: opx_core

export_include_dirs:
  - logic

sources:
  - include_dirs:
      - logic
    files:
      - logic/opx_pkg.sv
      - logic/opx_regfile.sv
      - logic/opx_fwd_ctrl.sv
      - logic/opx_operand_mux.sv
      - logic/opx_exec_stage.sv
      - logic/opx_core.sv
  - target: simulation
    files:
      - sim/opx_core_tb.sv

// File: sim/opx_core_trace.txt
// One line per cycle in hex, wb fields give the expected output at the end of that cycle
// id_freeze ex_freeze valid op rd ra rb use_imm imm wb_valid wb_rd wb_data
// All eight ALU ops, results two edges after issue
0 0 1 0 01 00 00 1 12345678 0 00 00000000
0 0 1 0 02 00 00 1 0000000f 0 00 00000000
0 0 1 0 03 00 00 1 fffffff0 1 01 12345678
0 0 1 1 04 01 00 1 00000678 1 02 0000000f
0 0 1 2 05 01 03 0 00000000 1 03 fffffff0
0 0 1 3 06 02 00 1 00000f00 1 04 12345000
0 0 1 4 07 01 03 0 00000000 1 05 12345670
0 0 1 5 08 02 00 1 00000024 1 06 00000f0f
0 0 1 6 09 03 02 0 00000000 1 07 edcba988
0 0 1 7 00 00 00 1 deadbeef 1 08 000000f0
// Read back r4 to r9 and r0 through operand B
0 0 1 7 00 00 04 0 00000000 1 09 0001ffff
0 0 1 7 00 00 05 0 00000000 1 00 deadbeef
0 0 1 7 00 00 06 0 00000000 1 00 12345000
0 0 1 7 00 00 07 0 00000000 1 00 12345670
0 0 1 7 00 00 08 0 00000000 1 00 00000f0f
0 0 1 7 00 00 09 0 00000000 1 00 edcba988
0 0 1 7 00 00 00 0 00000000 1 00 000000f0
// Dependent distances 1, 2 and 3
0 0 1 0 0a 00 00 1 00000100 1 00 0001ffff
0 0 1 0 0b 0a 0a 0 00000000 1 00 00000000
0 0 1 1 0c 0a 00 1 00000001 1 0a 00000100
0 0 1 4 0d 0a 0b 0 00000000 1 0b 00000200
// r14 in both EX and WB, younger value wins
0 0 1 0 0e 00 00 1 11111111 1 0c 000000ff
0 0 1 0 0e 00 00 1 22222222 1 0d 00000300
0 0 1 0 0f 0e 00 1 00000001 1 0e 11111111
// id_freeze on a dependent SUB
0 0 1 0 10 00 00 1 0000abcd 1 0e 22222222
1 0 1 1 11 10 00 1 00000001 1 0f 22222223
1 0 1 1 11 10 00 1 00000001 1 10 0000abcd
1 0 1 1 11 10 00 1 00000001 0 00 00000000
0 0 1 1 11 10 00 1 00000001 0 00 00000000
// ex_freeze holds r18 in EX, then drain
0 0 1 0 12 00 00 1 00000777 0 00 00000000
0 1 1 0 13 12 00 1 00000001 1 11 0000abcc
0 1 1 0 13 12 00 1 00000001 0 00 00000000
0 0 1 0 13 12 00 1 00000001 0 00 00000000
0 0 0 0 00 00 00 0 00000000 1 12 00000777
0 0 0 0 00 00 00 0 00000000 1 13 00000778
0 0 0 0 00 00 00 0 00000000 0 00 00000000

// File: sim/opx_core_tb.sv
`timescale 1ns/1ps

module opx_core_tb;

	localparam int CLK_PERIOD = 100;
	// Inputs change this long after the rising edge
	localparam int DRIVE_DELAY = 10;
	localparam string TRACE_FILE = "sim/opx_core_trace.txt";

	logic clk;
	logic rst;
	logic id_freeze;
	logic ex_freeze;
	opx_pkg::id_instr_t instr;
	opx_pkg::wb_result_t wb;

	// One entry per trace line, freeze bits are {id_freeze, ex_freeze}
	logic [1:0] freeze_q[$];
	opx_pkg::id_instr_t instr_q[$];
	opx_pkg::wb_result_t expect_q[$];
	logic trace_loaded;

	opx_core i_dut (
		.clk(clk),
		.rst(rst),
		.id_freeze(id_freeze),
		.ex_freeze(ex_freeze),
		.instr(instr),
		.wb(wb)
	);

	////////////////////////////////////////////////////
	// Clock and watchdog
	////////////////////////////////////////////////////

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// Trace length plus slack for reset and drain
	initial begin
		wait (trace_loaded === 1'b1);
		#((instr_q.size() + 10) * CLK_PERIOD);
		$display("Timeout, the trace did not finish in the expected time");
		$display("Testbench failed");
		$fatal(1, "watchdog expired");
	end

	////////////////////////////////////////////////////
	// Helpers
	////////////////////////////////////////////////////

	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("Testbench failed");
		$fatal(1, "run stopped on first error");
	endtask

	// Reads every data line of the trace into the queues
	task automatic load_trace();
		int fd;
		int n;
		string line;
		logic [31:0] t_idf, t_exf, t_valid, t_op, t_rd, t_ra, t_rb, t_ui, t_imm;
		logic [31:0] e_valid, e_rd, e_data;
		opx_pkg::id_instr_t ins;
		opx_pkg::wb_result_t res;
		fd = $fopen(TRACE_FILE, "r");
		if (fd == 0) begin
			abort_run({"Could not open the trace file ", TRACE_FILE});
		end else begin
			while ($fgets(line, fd) != 0) begin
				// Blank and comment lines carry no cycle
				if (line.len() < 2 || line.substr(0, 1) == "//") begin
					continue;
				end
				n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h",
					t_idf, t_exf, t_valid, t_op, t_rd, t_ra, t_rb, t_ui, t_imm,
					e_valid, e_rd, e_data);
				if (n != 12) begin
					abort_run($sformatf("Trace line %0d does not hold 12 fields",
						instr_q.size()));
				end else begin
					ins.valid = t_valid[0];
					ins.op = opx_pkg::alu_op_t'(t_op);
					ins.rd = opx_pkg::reg_addr_t'(t_rd);
					ins.ra = opx_pkg::reg_addr_t'(t_ra);
					ins.rb = opx_pkg::reg_addr_t'(t_rb);
					ins.use_imm = t_ui[0];
					ins.imm = opx_pkg::word_t'(t_imm);
					res.valid = e_valid[0];
					res.rd = opx_pkg::reg_addr_t'(e_rd);
					res.data = opx_pkg::word_t'(e_data);
					freeze_q.push_back({t_idf[0], t_exf[0]});
					instr_q.push_back(ins);
					expect_q.push_back(res);
				end
			end
			$fclose(fd);
		end
	endtask

	task automatic drive_inputs(input int idx);
		id_freeze = freeze_q[idx][1];
		ex_freeze = freeze_q[idx][0];
		instr = instr_q[idx];
	endtask

	// rd and data only matter for a valid result
	task automatic check_wb(
		input opx_pkg::wb_result_t exp,
		input opx_pkg::wb_result_t act,
		input int idx
	);
		if (act.valid !== exp.valid) begin
			abort_run($sformatf("** Error wb.valid expected %h actual %h at trace line %0d",
				exp.valid, act.valid, idx));
		end else if (exp.valid && (act.rd !== exp.rd)) begin
			abort_run($sformatf("** Error wb.rd expected %h actual %h at trace line %0d",
				exp.rd, act.rd, idx));
		end else if (exp.valid && (act.data !== exp.data)) begin
			abort_run($sformatf("** Error wb.data expected %h actual %h at trace line %0d",
				exp.data, act.data, idx));
		end
	endtask

	////////////////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////////////////

	initial begin
		rst = 1'b1;
		id_freeze = 1'b0;
		ex_freeze = 1'b0;
		instr = '0;
		trace_loaded = 1'b0;
		load_trace();
		if (instr_q.size() == 0) begin
			abort_run("The trace file holds no cycles");
		end
		trace_loaded = 1'b1;
		// Two reset edges, then release with the first cycle
		repeat (2) @(posedge clk);
		#(DRIVE_DELAY);
		rst = 1'b0;
		for (int i = 0; i < instr_q.size(); i++) begin
			if (i > 0) begin
				@(posedge clk);
				#(DRIVE_DELAY);
			end
			drive_inputs(i);
			// Sample just before the next edge
			#(CLK_PERIOD - 2 * DRIVE_DELAY);
			check_wb(expect_q[i], wb, i);
		end
		$display("Testbench passed");
		$finish;
	end

endmodule

// File: logic/opx_core.sv
`timescale 1ns/1ps

module opx_core (
	input logic clk,
	input logic rst,
	input logic id_freeze,
	input logic ex_freeze,
	input opx_pkg::id_instr_t instr,
	output opx_pkg::wb_result_t wb
);

	// Register file read data
	opx_pkg::word_t rf_a;
	opx_pkg::word_t rf_b;

	// Forwarded results and selects
	opx_pkg::word_t ex_forw;
	opx_pkg::word_t wb_forw;
	opx_pkg::opsel_t sel_a;
	opx_pkg::opsel_t sel_b;

	// Registered operands into EX
	opx_pkg::word_t operand_a;
	opx_pkg::word_t operand_b;

	// Destinations in flight
	opx_pkg::stage_tag_t ex_tag;
	opx_pkg::stage_tag_t wb_tag;

	////////////////////////////////////////////////////
	// ID side
	////////////////////////////////////////////////////

	// Write port fed straight from WB
	opx_regfile i_regfile (
		.clk(clk),
		.rst(rst),
		.ra(instr.ra),
		.rb(instr.rb),
		.wr(wb),
		.rf_a(rf_a),
		.rf_b(rf_b)
	);

	opx_fwd_ctrl i_fwd_ctrl (
		.instr(instr),
		.ex_tag(ex_tag),
		.wb_tag(wb_tag),
		.sel_a(sel_a),
		.sel_b(sel_b)
	);

	opx_operand_mux i_operand_mux (
		.clk(clk),
		.rst(rst),
		.id_freeze(id_freeze),
		.ex_freeze(ex_freeze),
		.rf_a(rf_a),
		.rf_b(rf_b),
		.ex_forw(ex_forw),
		.wb_forw(wb_forw),
		.imm(instr.imm),
		.sel_a(sel_a),
		.sel_b(sel_b),
		.operand_a(operand_a),
		.operand_b(operand_b)
	);

	////////////////////////////////////////////////////
	// EX and WB
	////////////////////////////////////////////////////

	opx_exec_stage i_exec_stage (
		.clk(clk),
		.rst(rst),
		.id_freeze(id_freeze),
		.ex_freeze(ex_freeze),
		.instr(instr),
		.operand_a(operand_a),
		.operand_b(operand_b),
		.ex_forw(ex_forw),
		.wb_forw(wb_forw),
		.ex_tag(ex_tag),
		.wb_tag(wb_tag),
		.wb(wb)
	);

endmodule

// File: logic/opx_exec_stage.sv
`timescale 1ns/1ps

module opx_exec_stage (
	input logic clk,
	input logic rst,
	input logic id_freeze,
	input logic ex_freeze,
	input opx_pkg::id_instr_t instr,
	input opx_pkg::word_t operand_a,
	input opx_pkg::word_t operand_b,
	output opx_pkg::word_t ex_forw,
	output opx_pkg::word_t wb_forw,
	output opx_pkg::stage_tag_t ex_tag,
	output opx_pkg::stage_tag_t wb_tag,
	output opx_pkg::wb_result_t wb
);

	// EX stage state
	logic ex_valid;
	opx_pkg::alu_op_t ex_op;
	opx_pkg::reg_addr_t ex_rd;
	opx_pkg::word_t alu_res;

	// WB stage state
	logic wb_valid;
	opx_pkg::reg_addr_t wb_rd;
	opx_pkg::word_t wb_data;

	////////////////////////////////////////////////////
	// EX tag
	////////////////////////////////////////////////////

	// A frozen ID sends a bubble into EX
	always_ff @(posedge clk) begin
		if (rst) begin
			ex_valid <= 1'b0;
		end else if (!ex_freeze) begin
			ex_valid <= instr.valid && !id_freeze;
		end
	end

	// Op and destination follow the valid bit
	always_ff @(posedge clk) begin
		if (!ex_freeze) begin
			ex_op <= instr.op;
			ex_rd <= instr.rd;
		end
	end

	////////////////////////////////////////////////////
	// ALU
	////////////////////////////////////////////////////

	always_comb begin
		alu_res = operand_b;
		case (ex_op)
			opx_pkg::ALU_ADD: alu_res = operand_a + operand_b;
			opx_pkg::ALU_SUB: alu_res = operand_a - operand_b;
			opx_pkg::ALU_AND: alu_res = operand_a & operand_b;
			opx_pkg::ALU_OR: alu_res = operand_a | operand_b;
			opx_pkg::ALU_XOR: alu_res = operand_a ^ operand_b;
			opx_pkg::ALU_SLL: alu_res = operand_a << operand_b[4:0];
			opx_pkg::ALU_SRL: alu_res = operand_a >> operand_b[4:0];
			opx_pkg::ALU_PASSB: alu_res = operand_b;
		endcase
	end

	////////////////////////////////////////////////////
	// WB register
	////////////////////////////////////////////////////

	// Held EX result goes to WB once, after the freeze drops
	always_ff @(posedge clk) begin
		if (rst) begin
			wb_valid <= 1'b0;
		end else begin
			wb_valid <= ex_valid && !ex_freeze;
		end
	end

	// Payload follows EX every cycle
	always_ff @(posedge clk) begin
		wb_rd <= ex_rd;
		wb_data <= alu_res;
	end

	// Forwarding and result outputs
	assign ex_forw = alu_res;
	assign wb_forw = wb_data;
	assign ex_tag = '{valid: ex_valid, rd: ex_rd};
	assign wb_tag = '{valid: wb_valid, rd: wb_rd};
	assign wb = '{valid: wb_valid, rd: wb_rd, data: wb_data};

endmodule

// File: logic/opx_operand_mux.sv
`timescale 1ns/1ps

module opx_operand_mux (
	input logic clk,
	input logic rst,
	input logic id_freeze,
	input logic ex_freeze,
	input opx_pkg::word_t rf_a,
	input opx_pkg::word_t rf_b,
	input opx_pkg::word_t ex_forw,
	input opx_pkg::word_t wb_forw,
	input opx_pkg::word_t imm,
	input opx_pkg::opsel_t sel_a,
	input opx_pkg::opsel_t sel_b,
	output opx_pkg::word_t operand_a,
	output opx_pkg::word_t operand_b
);

	// Index 0 is operand A, index 1 is operand B
	opx_pkg::word_t muxed [2];
	opx_pkg::word_t opnd [2];
	logic [1:0] saved;

	////////////////////////////////////////////////////
	// Source muxes
	////////////////////////////////////////////////////

	// Operand A has no immediate source
	always_comb begin
		case (sel_a)
			opx_pkg::SEL_EX: muxed[0] = ex_forw;
			opx_pkg::SEL_WB: muxed[0] = wb_forw;
			default: muxed[0] = rf_a;
		endcase
	end

	// Operand B
	always_comb begin
		case (sel_b)
			opx_pkg::SEL_IMM: muxed[1] = imm;
			opx_pkg::SEL_EX: muxed[1] = ex_forw;
			opx_pkg::SEL_WB: muxed[1] = wb_forw;
			default: muxed[1] = rf_b;
		endcase
	end

	////////////////////////////////////////////////////
	// Operand registers
	////////////////////////////////////////////////////

	// Load while EX moves, unless a value is already saved
	// First id_freeze cycle loads and marks the value saved,
	// later freeze cycles keep it since the producer may have left EX/WB
	// Flag drops when both freezes are low, the saved value enters EX
	always_ff @(posedge clk) begin
		for (int i = 0; i < 2; i++) begin
			if (rst) begin
				opnd[i] <= '0;
				saved[i] <= 1'b0;
			end else if (!ex_freeze && !saved[i]) begin
				opnd[i] <= muxed[i];
				saved[i] <= id_freeze;
			end else if (!ex_freeze && !id_freeze) begin
				saved[i] <= 1'b0;
			end
		end
	end

	assign operand_a = opnd[0];
	assign operand_b = opnd[1];

endmodule

// File: logic/opx_fwd_ctrl.sv
`timescale 1ns/1ps

module opx_fwd_ctrl (
	input opx_pkg::id_instr_t instr,
	input opx_pkg::stage_tag_t ex_tag,
	input opx_pkg::stage_tag_t wb_tag,
	output opx_pkg::opsel_t sel_a,
	output opx_pkg::opsel_t sel_b
);

	// Source matches a live destination in a later stage
	// r0 never forwards
	function automatic logic fwd_hit(
		input opx_pkg::reg_addr_t src,
		input opx_pkg::stage_tag_t tag
	);
		return tag.valid && (tag.rd == src) && (src != '0);
	endfunction

	////////////////////////////////////////////////////
	// Operand A select
	////////////////////////////////////////////////////

	// EX is younger than WB, so it is checked first
	always_comb begin
		if (fwd_hit(instr.ra, ex_tag)) begin
			sel_a = opx_pkg::SEL_EX;
		end else if (fwd_hit(instr.ra, wb_tag)) begin
			sel_a = opx_pkg::SEL_WB;
		end else begin
			sel_a = opx_pkg::SEL_RF;
		end
	end

	////////////////////////////////////////////////////
	// Operand B select
	////////////////////////////////////////////////////

	// Same priority as A, immediate ahead of the register file
	always_comb begin
		if (fwd_hit(instr.rb, ex_tag)) begin
			sel_b = opx_pkg::SEL_EX;
		end else if (fwd_hit(instr.rb, wb_tag)) begin
			sel_b = opx_pkg::SEL_WB;
		end else if (instr.use_imm) begin
			sel_b = opx_pkg::SEL_IMM;
		end else begin
			sel_b = opx_pkg::SEL_RF;
		end
	end

endmodule

// File: logic/opx_regfile.sv
`timescale 1ns/1ps
`include "opx_defs.svh"

module opx_regfile (
	input logic clk,
	input logic rst,
	input opx_pkg::reg_addr_t ra,
	input opx_pkg::reg_addr_t rb,
	input opx_pkg::wb_result_t wr,
	output opx_pkg::word_t rf_a,
	output opx_pkg::word_t rf_b
);

	localparam int DEPTH = 1 << `OPX_RADDR_W;

	// Register storage
	opx_pkg::word_t mem [DEPTH];

	////////////////////////////////////////////////////
	// Write port
	////////////////////////////////////////////////////

	// Whole array cleared on reset
	// r0 is never written
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < DEPTH; i++) begin
				mem[i] <= '0;
			end
		end else if (wr.valid && (wr.rd != '0)) begin
			mem[wr.rd] <= wr.data;
		end
	end

	////////////////////////////////////////////////////
	// Read ports
	////////////////////////////////////////////////////

	// Combinational reads, r0 forced to zero
	assign rf_a = (ra == '0) ? '0 : mem[ra];
	assign rf_b = (rb == '0) ? '0 : mem[rb];

endmodule

// File: logic/opx_pkg.sv
`include "opx_defs.svh"

package opx_pkg;

	////////////////////////////////////////////////////
	// Vector types
	////////////////////////////////////////////////////

	typedef logic [`OPX_WIDTH-1:0] word_t;
	typedef logic [`OPX_RADDR_W-1:0] reg_addr_t;
	typedef logic [`OPX_SEL_W-1:0] opsel_t;
	typedef logic [`OPX_OP_W-1:0] alu_op_t;

	// Operand source selects
	localparam opsel_t SEL_RF = opsel_t'(0);
	// Immediate is only a source for operand B
	localparam opsel_t SEL_IMM = opsel_t'(1);
	localparam opsel_t SEL_EX = opsel_t'(2);
	localparam opsel_t SEL_WB = opsel_t'(3);

	// ALU operations
	localparam alu_op_t ALU_ADD = alu_op_t'(0);
	localparam alu_op_t ALU_SUB = alu_op_t'(1);
	localparam alu_op_t ALU_AND = alu_op_t'(2);
	localparam alu_op_t ALU_OR = alu_op_t'(3);
	localparam alu_op_t ALU_XOR = alu_op_t'(4);
	// Shift amounts come from the low 5 bits of B
	localparam alu_op_t ALU_SLL = alu_op_t'(5);
	localparam alu_op_t ALU_SRL = alu_op_t'(6);
	localparam alu_op_t ALU_PASSB = alu_op_t'(7);

	////////////////////////////////////////////////////
	// Pipeline structs
	////////////////////////////////////////////////////

	// Decoded instruction at ID, imm already sign-extended
	typedef struct packed {
		logic valid;
		alu_op_t op;
		reg_addr_t rd;
		reg_addr_t ra;
		reg_addr_t rb;
		logic use_imm;
		word_t imm;
	} id_instr_t;

	// Destination of the instruction in EX or WB
	typedef struct packed {
		logic valid;
		reg_addr_t rd;
	} stage_tag_t;

	// Write-back result
	typedef struct packed {
		logic valid;
		reg_addr_t rd;
		word_t data;
	} wb_result_t;

endpackage

// File: logic/opx_defs.svh
`ifndef OPX_DEFS_SVH
`define OPX_DEFS_SVH

////////////////////////////////////////////////////
// Data path widths
////////////////////////////////////////////////////

// Width of a data word and of both ALU operands
`define OPX_WIDTH 32

// Register number width, gives 32 registers
`define OPX_RADDR_W 5

// Operand source select width
`define OPX_SEL_W 2

// ALU operation code width
`define OPX_OP_W 3

`endif
